// ==== icache_pkg.sv ====
/*
 * Shared types and geometry constants of the instruction cache:
 * address, word, index, tag and word-select vectors, and the
 * controller state encoding.
 */
package icache_pkg;

  // Address and data widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // Line geometry: 4 words of 4 bytes, 16 sets
  localparam int BYTE_OFF_W = 2;
  localparam int LINE_WORDS = 4;
  localparam int WORD_OFF_W = 2;
  localparam int INDEX_W    = 4;
  localparam int TAG_W      = 32 - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

  // Bit positions inside a byte address
  localparam int WORD_LSB  = BYTE_OFF_W;
  localparam int INDEX_LSB = BYTE_OFF_W + WORD_OFF_W;
  localparam int TAG_LSB   = BYTE_OFF_W + WORD_OFF_W + INDEX_W;

  typedef logic [WORD_OFF_W-1:0] word_sel_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [TAG_W-1:0]      tag_t;

  // Controller states
  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_MISS_REQ,
    S_REFILL,
    S_REPLAY,
    S_UNCACHED,
    S_FLUSH
  } ctrl_state_e;

endpackage

// ==== fetch_if_adapter.sv ====
/*
 * Core-side fetch adapter: two-phase request (index, then tag),
 * cacheability check against a region limit, kill to abort,
 * response mapping back to the core.
 */
`timescale 1ns/1ps

module fetch_if_adapter #(
  parameter icache_pkg::addr_t CACHEABLE_LIMIT = 32'h8000_0000
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Core fetch port
  input  logic                   fetch_req_valid_i,
  input  icache_pkg::addr_t      fetch_vindex_i,
  output logic                   fetch_ready_o,
  input  icache_pkg::tag_t       fetch_ptag_i,
  input  logic                   fetch_kill_i,
  output logic                   fetch_rsp_valid_o,
  output icache_pkg::word_t      fetch_rsp_data_o,

  // Cache controller port
  input  logic                   ctrl_ready_i,
  output logic                   cache_req_o,
  output icache_pkg::index_t     cache_index_o,
  output icache_pkg::word_sel_t  cache_word_o,
  output icache_pkg::tag_t       cache_tag_o,
  output logic                   cache_uncached_o,
  output logic                   cache_abort_o,
  input  logic                   cache_rsp_valid_i,
  input  icache_pkg::word_t      cache_rsp_data_i
);

  import icache_pkg::*;

  logic  accepted_q;
  logic  req_fire;
  addr_t tag_base;

  assign req_fire = fetch_req_valid_i & ctrl_ready_i;

  // Request accepted in the previous cycle, tag phase is now
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accepted_q <= 1'b0;
    end else begin
      accepted_q <= req_fire;
    end
  end

  // Index phase
  assign fetch_ready_o = ctrl_ready_i;
  assign cache_req_o   = req_fire;
  assign cache_index_o = fetch_vindex_i[INDEX_LSB +: INDEX_W];
  assign cache_word_o  = fetch_vindex_i[WORD_LSB +: WORD_OFF_W];

  // Tag phase: region check uses the line base of the physical tag
  assign tag_base         = {fetch_ptag_i, {TAG_LSB{1'b0}}};
  assign cache_tag_o      = fetch_ptag_i;
  assign cache_uncached_o = (tag_base >= CACHEABLE_LIMIT);
  assign cache_abort_o    = accepted_q & fetch_kill_i;

  // Responses go back as they are
  assign fetch_rsp_valid_o = cache_rsp_valid_i;
  assign fetch_rsp_data_o  = cache_rsp_data_i;

  // Kill is only meaningful in the tag cycle of an accepted fetch
  a_kill_after_accept : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(fetch_kill_i) |-> accepted_q
  ) else $error("fetch_kill_i raised outside a tag cycle");

endmodule

// ==== icache_ctrl_fsm.sv ====
/*
 * Cache controller FSM: lookup and hit check, line refill,
 * replay after refill, uncacheable single-word reads and flush.
 */
`timescale 1ns/1ps

module icache_ctrl_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // From the fetch adapter
  input  logic                   cache_req_i,
  input  icache_pkg::index_t     cache_index_i,
  input  icache_pkg::word_sel_t  cache_word_i,
  input  icache_pkg::tag_t       cache_tag_i,
  input  logic                   cache_uncached_i,
  input  logic                   cache_abort_i,
  input  logic                   flush_i,
  output logic                   ready_o,

  // Array read results
  input  icache_pkg::tag_t       rd_tag_i,
  input  logic                   rd_valid_i,
  input  icache_pkg::word_t      rd_data_i,

  // Array control
  output icache_pkg::index_t     arr_index_o,
  output icache_pkg::word_sel_t  arr_word_o,
  output logic                   tag_we_o,
  output icache_pkg::tag_t       tag_wtag_o,
  output logic                   inval_all_o,
  output logic                   data_we_o,
  output icache_pkg::word_sel_t  data_wword_o,
  output icache_pkg::word_t      data_wdata_o,

  // Refill beat counter
  output logic                   cnt_start_o,
  input  icache_pkg::word_sel_t  beat_word_i,
  input  logic                   beat_last_i,

  // Memory side
  input  logic                   mem_beat_i,
  input  icache_pkg::word_t      mem_data_i,
  output logic                   mem_req_o,
  output icache_pkg::addr_t      mem_addr_o,
  output logic                   mem_single_o,

  // Response
  output logic                   rsp_valid_o,
  output icache_pkg::word_t      rsp_data_o
);

  import icache_pkg::*;

  ctrl_state_e state_q, state_d;
  index_t      index_q;
  word_sel_t   word_q;
  tag_t        tag_q;
  logic        uncached_q;
  logic        flush_pend_q;
  logic        flush_go;
  logic        hit;
  logic        rsp_valid_d, rsp_mem_d;
  logic        rsp_valid_q;
  logic        rsp_mem_q;
  word_t       unc_data_q;

  // A flush wins over a fetch in the same idle cycle
  assign flush_go = flush_i | flush_pend_q;
  assign hit      = !cache_uncached_i && rd_valid_i && (rd_tag_i == cache_tag_i);

  always_comb begin
    state_d     = state_q;
    ready_o     = 1'b0;
    tag_we_o    = 1'b0;
    inval_all_o = 1'b0;
    data_we_o   = 1'b0;
    cnt_start_o = 1'b0;
    mem_req_o   = 1'b0;
    rsp_valid_d = 1'b0;
    rsp_mem_d   = 1'b0;
    case (state_q)
      S_IDLE: begin
        ready_o = !flush_go;
        if (flush_go) begin
          state_d = S_FLUSH;
        end else if (cache_req_i) begin
          state_d = S_LOOKUP;
        end
      end
      S_LOOKUP: begin
        if (cache_abort_i) begin
          state_d = S_IDLE;
        end else if (hit) begin
          rsp_valid_d = 1'b1;
          state_d     = S_IDLE;
        end else begin
          state_d = S_MISS_REQ;
        end
      end
      S_MISS_REQ: begin
        mem_req_o   = 1'b1;
        cnt_start_o = 1'b1;
        state_d     = uncached_q ? S_UNCACHED : S_REFILL;
      end
      S_REFILL: begin
        if (mem_beat_i) begin
          data_we_o = 1'b1;
          if (beat_last_i) begin
            tag_we_o = 1'b1;
            state_d  = S_REPLAY;
          end
        end
      end
      S_REPLAY: begin
        // Array read issued here, word shows up next cycle
        rsp_valid_d = 1'b1;
        state_d     = S_IDLE;
      end
      S_UNCACHED: begin
        if (mem_beat_i) begin
          rsp_valid_d = 1'b1;
          rsp_mem_d   = 1'b1;
          state_d     = S_IDLE;
        end
      end
      S_FLUSH: begin
        inval_all_o = 1'b1;
        state_d     = S_IDLE;
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= S_IDLE;
      flush_pend_q <= 1'b0;
      rsp_valid_q  <= 1'b0;
      rsp_mem_q    <= 1'b0;
    end else begin
      state_q      <= state_d;
      flush_pend_q <= (flush_pend_q | flush_i) & (state_q != S_IDLE);
      rsp_valid_q  <= rsp_valid_d;
      rsp_mem_q    <= rsp_mem_d;
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE && cache_req_i) begin
      index_q <= cache_index_i;
      word_q  <= cache_word_i;
    end
    if (state_q == S_LOOKUP) begin
      tag_q      <= cache_tag_i;
      uncached_q <= cache_uncached_i;
    end
    if (state_q == S_UNCACHED && mem_beat_i) begin
      unc_data_q <= mem_data_i;
    end
  end

  // Array address follows the core while idle
  assign arr_index_o  = (state_q == S_IDLE) ? cache_index_i : index_q;
  assign arr_word_o   = (state_q == S_IDLE) ? cache_word_i : word_q;
  assign tag_wtag_o   = tag_q;
  assign data_wword_o = beat_word_i;
  assign data_wdata_o = mem_data_i;

  assign mem_single_o = uncached_q;
  assign mem_addr_o   = uncached_q ? {tag_q, index_q, word_q, {BYTE_OFF_W{1'b0}}}
                                   : {tag_q, index_q, {(WORD_OFF_W + BYTE_OFF_W){1'b0}}};

  // Hit and replay data come straight from the array output register
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = rsp_mem_q ? unc_data_q : rd_data_i;

  a_no_beat_idle : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q == S_IDLE) |-> !mem_beat_i
  ) else $error("memory beat while no request is outstanding");

  a_rsp_single : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |=> !rsp_valid_o
  ) else $error("response valid in two consecutive cycles");

endmodule

// ==== refill_beat_counter.sv ====
/*
 * Refill beat counter: word slot of the current beat, last-beat flag
 */
`timescale 1ns/1ps

module refill_beat_counter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  logic                   beat_i,
  output icache_pkg::word_sel_t  beat_word_o,
  output logic                   last_o
);

  import icache_pkg::*;

  word_sel_t cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= '0;
    end else if (beat_i) begin
      cnt_q <= cnt_q + word_sel_t'(1);
    end
  end

  // Slot of the beat arriving in this cycle
  assign beat_word_o = cnt_q;
  assign last_o      = (cnt_q == word_sel_t'(LINE_WORDS - 1));

endmodule

// ==== icache_tag_array.sv ====
/*
 * Tag array with per-set valid bits, registered read
 * and single-cycle invalidation of all sets.
 */
`timescale 1ns/1ps

module icache_tag_array #(
  parameter int SETS = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  icache_pkg::index_t  rd_index_i,
  input  logic                we_i,
  input  icache_pkg::index_t  wr_index_i,
  input  icache_pkg::tag_t    wr_tag_i,
  input  logic                inval_all_i,
  output icache_pkg::tag_t    rd_tag_o,
  output logic                rd_valid_o
);

  import icache_pkg::*;

  tag_t            tag_mem [SETS];
  logic [SETS-1:0] valid_q;

  // Valid bits, flash clear has priority over a fill
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      if (inval_all_i) begin
        valid_q <= '0;
      end else if (we_i) begin
        valid_q[wr_index_i] <= 1'b1;
      end
      rd_valid_o <= valid_q[rd_index_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      tag_mem[wr_index_i] <= wr_tag_i;
    end
    rd_tag_o <= tag_mem[rd_index_i];
  end

  // Index width and set count must describe the same array
  a_sets_match : assert property (
    @(posedge clk_i) SETS == (1 << INDEX_W)
  ) else $error("SETS does not match INDEX_W");

endmodule

// ==== icache_data_array.sv ====
/*
 * Data array, one word per set and slot, registered read
 */
`timescale 1ns/1ps

module icache_data_array #(
  parameter int SETS = 16
) (
  input  logic                   clk_i,
  input  icache_pkg::index_t     rd_index_i,
  input  icache_pkg::word_sel_t  rd_word_i,
  input  logic                   we_i,
  input  icache_pkg::index_t     wr_index_i,
  input  icache_pkg::word_sel_t  wr_word_i,
  input  icache_pkg::word_t      wr_data_i,
  output icache_pkg::word_t      rd_data_o
);

  import icache_pkg::*;

  word_t data_mem [SETS][LINE_WORDS];

  // Refill writes one word per beat
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      data_mem[wr_index_i][wr_word_i] <= wr_data_i;
    end
    rd_data_o <= data_mem[rd_index_i][rd_word_i];
  end

endmodule

// ==== icache_subsys_top.sv ====
/*
 * Instruction fetch subsystem: fetch adapter, cache controller,
 * refill counter, tag array and data array.
 */
`timescale 1ns/1ps

module icache_subsys_top #(
  parameter icache_pkg::addr_t CACHEABLE_LIMIT = 32'h8000_0000,
  parameter int                SETS            = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Core side
  input  logic                fetch_req_valid_i,
  input  icache_pkg::addr_t   fetch_vindex_i,
  output logic                fetch_ready_o,
  input  icache_pkg::tag_t    fetch_ptag_i,
  input  logic                fetch_kill_i,
  output logic                fetch_rsp_valid_o,
  output icache_pkg::word_t   fetch_rsp_data_o,
  input  logic                flush_i,

  // Memory side
  output logic                mem_req_o,
  output icache_pkg::addr_t   mem_addr_o,
  output logic                mem_single_o,
  input  logic                mem_beat_i,
  input  icache_pkg::word_t   mem_data_i
);

  import icache_pkg::*;

  logic      ctrl_ready;
  logic      cache_req, cache_uncached, cache_abort;
  index_t    cache_index;
  word_sel_t cache_word;
  tag_t      cache_tag;
  logic      cache_rsp_valid;
  word_t     cache_rsp_data;

  index_t    arr_index;
  word_sel_t arr_word;
  tag_t      rd_tag, tag_wtag;
  logic      rd_valid;
  word_t     rd_data;
  logic      tag_we, inval_all, data_we;
  word_sel_t data_wword;
  word_t     data_wdata;

  logic      cnt_start, beat_last;
  word_sel_t beat_word;

  fetch_if_adapter #(
    .CACHEABLE_LIMIT (CACHEABLE_LIMIT)
  ) u_adapter (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .fetch_req_valid_i (fetch_req_valid_i),
    .fetch_vindex_i    (fetch_vindex_i),
    .fetch_ready_o     (fetch_ready_o),
    .fetch_ptag_i      (fetch_ptag_i),
    .fetch_kill_i      (fetch_kill_i),
    .fetch_rsp_valid_o (fetch_rsp_valid_o),
    .fetch_rsp_data_o  (fetch_rsp_data_o),
    .ctrl_ready_i      (ctrl_ready),
    .cache_req_o       (cache_req),
    .cache_index_o     (cache_index),
    .cache_word_o      (cache_word),
    .cache_tag_o       (cache_tag),
    .cache_uncached_o  (cache_uncached),
    .cache_abort_o     (cache_abort),
    .cache_rsp_valid_i (cache_rsp_valid),
    .cache_rsp_data_i  (cache_rsp_data)
  );

  icache_ctrl_fsm u_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cache_req_i      (cache_req),
    .cache_index_i    (cache_index),
    .cache_word_i     (cache_word),
    .cache_tag_i      (cache_tag),
    .cache_uncached_i (cache_uncached),
    .cache_abort_i    (cache_abort),
    .flush_i          (flush_i),
    .ready_o          (ctrl_ready),
    .rd_tag_i         (rd_tag),
    .rd_valid_i       (rd_valid),
    .rd_data_i        (rd_data),
    .arr_index_o      (arr_index),
    .arr_word_o       (arr_word),
    .tag_we_o         (tag_we),
    .tag_wtag_o       (tag_wtag),
    .inval_all_o      (inval_all),
    .data_we_o        (data_we),
    .data_wword_o     (data_wword),
    .data_wdata_o     (data_wdata),
    .cnt_start_o      (cnt_start),
    .beat_word_i      (beat_word),
    .beat_last_i      (beat_last),
    .mem_beat_i       (mem_beat_i),
    .mem_data_i       (mem_data_i),
    .mem_req_o        (mem_req_o),
    .mem_addr_o       (mem_addr_o),
    .mem_single_o     (mem_single_o),
    .rsp_valid_o      (cache_rsp_valid),
    .rsp_data_o       (cache_rsp_data)
  );

  refill_beat_counter u_beat_cnt (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (cnt_start),
    .beat_i      (mem_beat_i),
    .beat_word_o (beat_word),
    .last_o      (beat_last)
  );

  // Reads and refill writes share the controller's index
  icache_tag_array #(
    .SETS (SETS)
  ) u_tag_array (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_index_i  (arr_index),
    .we_i        (tag_we),
    .wr_index_i  (arr_index),
    .wr_tag_i    (tag_wtag),
    .inval_all_i (inval_all),
    .rd_tag_o    (rd_tag),
    .rd_valid_o  (rd_valid)
  );

  icache_data_array #(
    .SETS (SETS)
  ) u_data_array (
    .clk_i      (clk_i),
    .rd_index_i (arr_index),
    .rd_word_i  (arr_word),
    .we_i       (data_we),
    .wr_index_i (arr_index),
    .wr_word_i  (data_wword),
    .wr_data_i  (data_wdata),
    .rd_data_o  (rd_data)
  );

endmodule

// ==== tb_mem_responder.sv ====
/*
 * Memory model for the cache: answers line and single-word requests
 * with delayed, gapped beats of an address-derived pattern.
 */
`timescale 1ns/1ps

module tb_mem_responder (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               mem_req_i,
  input  icache_pkg::addr_t  mem_addr_i,
  input  logic               mem_single_i,
  output logic               mem_beat_o,
  output icache_pkg::word_t  mem_data_o
);

  import icache_pkg::*;

  // Memory content, a function of the word address
  function automatic word_t beat_data(input addr_t addr);
    word_t mixed;
    mixed = addr ^ 32'h5a5a_0000;
    return {mixed[24:0], mixed[31:25]};
  endfunction

  initial begin
    addr_t base;
    int    beats;
    mem_beat_o = 1'b0;
    mem_data_o = '0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_req_i) begin
        base  = mem_addr_i;
        beats = mem_single_i ? 1 : LINE_WORDS;
        repeat ($urandom_range(2, 6)) @(negedge clk_i);
        // Beats in address order, random gaps in between
        for (int i = 0; i < beats; i++) begin
          mem_beat_o = 1'b1;
          mem_data_o = beat_data(base + addr_t'(4 * i));
          @(negedge clk_i);
          mem_beat_o = 1'b0;
          mem_data_o = '0;
          if (i < beats - 1) begin
            repeat ($urandom_range(0, 2)) @(negedge clk_i);
          end
        end
      end
    end
  end

endmodule

// ==== tb_icache_subsys.sv ====
/*
 * Testbench of the instruction fetch subsystem: directed and random
 * fetches, kills and flushes against a model of tags and memory.
 */
`timescale 1ns/1ps

module tb_icache_subsys;

  import icache_pkg::*;

  localparam addr_t LIMIT   = 32'h8000_0000;
  localparam int    TIMEOUT = 60;

  logic  clk;
  logic  rst_n;
  logic  fetch_req_valid;
  logic  fetch_ready;
  logic  fetch_kill;
  logic  flush;
  addr_t fetch_vindex;
  tag_t  fetch_ptag;
  logic  fetch_rsp_valid;
  word_t fetch_rsp_data;
  logic  mem_req;
  logic  mem_single;
  logic  mem_beat;
  addr_t mem_addr;
  word_t mem_data;

  // Reference model state
  word_t exp_rsp_q[$];
  tag_t  model_tag [16];
  logic  model_valid [16];
  int    exp_mem_reqs;
  int    mem_reqs;
  int    rsp_count;
  addr_t exp_req_addr;
  logic  exp_req_single;
  int    errors;
  logic  timed_out;

  icache_subsys_top #(
    .CACHEABLE_LIMIT (LIMIT),
    .SETS            (16)
  ) uut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .fetch_req_valid_i (fetch_req_valid),
    .fetch_vindex_i    (fetch_vindex),
    .fetch_ready_o     (fetch_ready),
    .fetch_ptag_i      (fetch_ptag),
    .fetch_kill_i      (fetch_kill),
    .fetch_rsp_valid_o (fetch_rsp_valid),
    .fetch_rsp_data_o  (fetch_rsp_data),
    .flush_i           (flush),
    .mem_req_o         (mem_req),
    .mem_addr_o        (mem_addr),
    .mem_single_o      (mem_single),
    .mem_beat_i        (mem_beat),
    .mem_data_i        (mem_data)
  );

  tb_mem_responder u_mem (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .mem_req_i    (mem_req),
    .mem_addr_i   (mem_addr),
    .mem_single_i (mem_single),
    .mem_beat_o   (mem_beat),
    .mem_data_o   (mem_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Expected memory word at a word address
  function automatic word_t mem_word(input addr_t addr);
    word_t mixed;
    mixed = addr ^ 32'h5a5a_0000;
    return {mixed[24:0], mixed[31:25]};
  endfunction

  function automatic addr_t random_addr(input logic uncached);
    tag_t      tag;
    index_t    idx;
    word_sel_t word;
    tag  = uncached ? (24'h90_0000 | tag_t'($urandom_range(0, 15)))
                    : tag_t'($urandom_range(16, 19));
    idx  = index_t'($urandom_range(0, 15));
    word = word_sel_t'($urandom_range(0, 3));
    return {tag, idx, word, 2'b00};
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string msg);
    errors++;
    timed_out = 1'b1;
    $display("Timeout at %0t: %s", $time, msg);
  endtask

  // Compares every response and memory request as it happens
  always @(negedge clk) begin : monitor
    word_t expected;
    if (rst_n && fetch_rsp_valid) begin
      rsp_count++;
      if (exp_rsp_q.size() == 0) begin
        report_error($sformatf("unexpected response %h", fetch_rsp_data));
      end else begin
        expected = exp_rsp_q.pop_front();
        if (fetch_rsp_data !== expected) begin
          report_error($sformatf("data %h, expected %h", fetch_rsp_data, expected));
        end
      end
    end
    if (rst_n && mem_req) begin
      mem_reqs++;
      if (mem_addr !== exp_req_addr || mem_single !== exp_req_single) begin
        report_error($sformatf("mem request %h single %b, expected %h single %b",
                               mem_addr, mem_single, exp_req_addr, exp_req_single));
      end
    end
  end

  task automatic fetch(input addr_t addr, input logic kill);
    int   wait_cycles;
    int   idx;
    int   reqs_before;
    logic cacheable;
    logic hit;
    if (timed_out) return;
    idx       = addr[7:4];
    cacheable = addr < LIMIT;
    hit       = cacheable && model_valid[idx] && (model_tag[idx] == addr[31:8]);
    wait_cycles = 0;
    do begin
      @(negedge clk);
      wait_cycles++;
    end while (!fetch_ready && wait_cycles < TIMEOUT);
    if (!fetch_ready) begin
      report_timeout("fetch_ready_o stayed low");
      return;
    end
    exp_req_single  = !cacheable;
    exp_req_addr    = cacheable ? {addr[31:4], 4'h0} : {addr[31:2], 2'b00};
    reqs_before     = mem_reqs;
    fetch_req_valid = 1'b1;
    fetch_vindex    = addr;
    @(negedge clk);
    // Tag cycle
    fetch_req_valid = 1'b0;
    fetch_ptag      = addr[31:8];
    fetch_kill      = kill;
    if (kill) begin
      @(negedge clk);
      fetch_kill = 1'b0;
      if (!fetch_ready) report_error("controller not idle after a kill");
      repeat (4) @(negedge clk);
      if (mem_reqs != reqs_before) report_error("memory request after a kill");
      return;
    end
    if (!hit) exp_mem_reqs++;
    exp_rsp_q.push_back(mem_word({addr[31:2], 2'b00}));
    // Cycles counted from acceptance, the tag cycle is the first
    wait_cycles = 1;
    do begin
      @(negedge clk);
      wait_cycles++;
    end while (!fetch_rsp_valid && wait_cycles < TIMEOUT);
    if (!fetch_rsp_valid) begin
      report_timeout($sformatf("no response for fetch of %h", addr));
      return;
    end
    if (hit && wait_cycles != 2) begin
      report_error($sformatf("hit at %h answered after %0d cycles", addr, wait_cycles));
    end
    if (cacheable && !hit) begin
      model_valid[idx] = 1'b1;
      model_tag[idx]   = addr[31:8];
    end
    if (mem_reqs != exp_mem_reqs) begin
      report_error($sformatf("%0d memory requests, expected %0d", mem_reqs, exp_mem_reqs));
    end
  endtask

  task automatic flush_cache();
    if (timed_out) return;
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    for (int i = 0; i < 16; i++) begin
      model_valid[i] = 1'b0;
    end
  endtask

  initial begin
    int    op;
    int    reqs_before;
    addr_t line;
    void'($urandom(32'h926b_79dd));
    rst_n           = 1'b0;
    fetch_req_valid = 1'b0;
    fetch_vindex    = '0;
    fetch_ptag      = '0;
    fetch_kill      = 1'b0;
    flush           = 1'b0;
    errors          = 0;
    exp_mem_reqs    = 0;
    mem_reqs        = 0;
    rsp_count       = 0;
    exp_req_addr    = '0;
    exp_req_single  = 1'b0;
    timed_out       = 1'b0;
    for (int i = 0; i < 16; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (!fetch_ready || fetch_rsp_valid || mem_req) report_error("wrong outputs after reset");

    // Cold miss, then hits on every word of the line
    line = 32'h0001_2340;
    fetch(line + 32'h8, 1'b0);
    for (int w = 0; w < LINE_WORDS; w++) begin
      fetch(line + addr_t'(4 * w), 1'b0);
    end

    // Uncacheable region in the same set as the line, repeats included
    repeat (3) fetch(32'h9000_0148, 1'b0);
    fetch(line, 1'b0);

    // Killed fetch, then the same address for real
    fetch(32'h0000_5670, 1'b1);
    fetch(32'h0000_5670, 1'b0);

    // Flush, then two tags fighting over set 0
    flush_cache();
    fetch(line, 1'b0);
    reqs_before = mem_reqs;
    fetch(32'h0000_3300, 1'b0);
    fetch(32'h0004_7300, 1'b0);
    fetch(32'h0000_3300, 1'b0);
    if (!timed_out && mem_reqs - reqs_before != 3) report_error("conflicting tags did not evict");

    for (int n = 0; n < 300; n++) begin
      op = $urandom_range(0, 9);
      if (op == 0) begin
        flush_cache();
      end else if (op == 1) begin
        fetch(random_addr(1'b0), 1'b1);
      end else if (op == 2) begin
        fetch(random_addr(1'b1), 1'b0);
      end else begin
        fetch(random_addr(1'b0), 1'b0);
      end
    end

    repeat (4) @(negedge clk);
    if (exp_rsp_q.size() != 0) report_error("responses missing at the end");
    $display("Responses: %0d, memory requests: %0d of %0d expected, errors: %0d",
             rsp_count, mem_reqs, exp_mem_reqs, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
icache_pkg.sv
fetch_if_adapter.sv
icache_ctrl_fsm.sv
refill_beat_counter.sv
icache_tag_array.sv
icache_data_array.sv
icache_subsys_top.sv
tb_mem_responder.sv
tb_icache_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_icache_subsys -f tb.f -o tb_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0
